//--- logic/camera_pkg.sv
// camera_pkg
// video-side types for the OV7670 capture path: sensor bytes, RGB565
// green field and the capture FSM state encoding
package camera_pkg;

    typedef logic [7:0] pixel_byte_t;  // one sensor byte

    // RGB565 arrives as two bytes: RRRRRGGG then GGGBBBBB
    localparam int GREEN_WIDTH     = 6;
    localparam int GREEN_HIGH_BITS = 3;  // green bits carried by the first byte

    typedef logic [GREEN_WIDTH-1:0] green_t;

    function automatic green_t extract_green(input pixel_byte_t first_byte,
                                             input pixel_byte_t second_byte);
        return {first_byte[GREEN_HIGH_BITS-1:0],
                second_byte[7 -: (GREEN_WIDTH - GREEN_HIGH_BITS)]};
    endfunction

    typedef enum logic [3:0] {
        st_idle                 = 4'd0,
        st_wait_frame           = 4'd1,
        st_wait_line            = 4'd2,
        st_wait_first_byte      = 4'd3,
        st_wait_second_byte     = 4'd4,
        st_store_pixel          = 4'd5,
        st_next_pixel           = 4'd6,
        st_next_quadrant_column = 4'd7,
        st_line_done            = 4'd8,
        st_report               = 4'd9
    } capture_state_t;

endpackage

//--- logic/quadrant_stats_pkg.sv
// quadrant_stats_pkg
// result-side types: per-quadrant sum format and index sizing
package quadrant_stats_pkg;

    localparam int SUM_WIDTH = 16;

    typedef logic [SUM_WIDTH-1:0] quad_sum_t;  // unsigned, saturating

    localparam quad_sum_t SUM_MAX = '1;

    // bits needed to index count items, never less than one
    function automatic int quad_index_width(input int count);
        int width;
        width = 1;
        if (count > 1) begin
            width = $clog2(count);
        end
        return width;
    endfunction

endpackage

//--- logic/capture_count_if.sv
// capture_count_if
// counter commands from the capture FSM and position flags back from
// the position counters, with a read-only view for the accumulator
`timescale 1ns/1ps

interface capture_count_if
    import quadrant_stats_pkg::*;
#(
    parameter int NUM_QUADS = 4
) ();

    localparam int INDEX_WIDTH = quad_index_width(NUM_QUADS);

    logic                   clear_frame;        // all counters back to zero
    logic                   clear_line;         // column counters back to zero
    logic                   step_pixel;
    logic                   step_line;
    logic                   last_pixel_in_quad;
    logic                   last_line_in_quad;
    logic [INDEX_WIDTH-1:0] quad_index;         // quadrant of the current pixel

    modport control (
        output clear_frame, clear_line, step_pixel, step_line,
        input  last_pixel_in_quad
    );

    modport counters (
        input  clear_frame, clear_line, step_pixel, step_line,
        output last_pixel_in_quad, last_line_in_quad, quad_index
    );

    modport reader (
        input quad_index, clear_frame
    );

endinterface

//--- logic/capture_control.sv
// capture_control
// FSM following the OV7670 frame, line and byte timing; drives the
// position counters, the accumulator and the start of the report
`timescale 1ns/1ps

module capture_control
    import camera_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    input  logic            vsync,
    input  logic            href,
    input  logic            byte_valid,
    capture_count_if.control count,
    output logic            store_pixel,
    output logic            capture_first,
    output logic            report_start,
    input  logic            report_done,
    output logic            busy
);

    capture_state_t state, next_state;
    logic           vsync_q;
    logic           vsync_fall;

    // frame starts on the falling edge of vsync
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vsync_q <= 1'b0;
        end else begin
            vsync_q <= vsync;
        end
    end

    assign vsync_fall = vsync_q & ~vsync;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:                 if (start) next_state = st_wait_frame;
            st_wait_frame:           if (vsync_fall) next_state = st_wait_line;
            st_wait_line: begin
                if (vsync) begin
                    next_state = st_report;  // frame over
                end else if (href) begin
                    next_state = st_wait_first_byte;
                end
            end
            st_wait_first_byte: begin
                if (!href) begin
                    next_state = st_line_done;
                end else if (byte_valid) begin
                    next_state = st_wait_second_byte;
                end
            end
            st_wait_second_byte: begin
                if (!href) begin
                    next_state = st_line_done;
                end else if (byte_valid) begin
                    next_state = st_store_pixel;
                end
            end
            st_store_pixel: begin
                if (count.last_pixel_in_quad) begin
                    next_state = st_next_quadrant_column;
                end else begin
                    next_state = st_next_pixel;
                end
            end
            st_next_quadrant_column: next_state = st_next_pixel;
            st_next_pixel:           next_state = st_wait_first_byte;
            st_line_done:            next_state = st_wait_line;
            st_report:               if (report_done) next_state = st_idle;
            default:                 next_state = st_idle;
        endcase
    end

    always_comb begin
        count.clear_frame = (state == st_wait_frame);
        count.clear_line  = (state == st_line_done);
        count.step_line   = (state == st_line_done);
        // quadrant boundary steps in its own state, other pixels step right away
        count.step_pixel  = (state == st_next_quadrant_column) ||
                            ((state == st_store_pixel) && !count.last_pixel_in_quad);

        capture_first = (state == st_wait_first_byte) && href && byte_valid;
        store_pixel   = (state == st_wait_second_byte) && href && byte_valid;
        report_start  = (state == st_wait_line) && vsync;  // entry into report
        busy          = (state != st_idle);
    end

    // no pixel lands in a sum that is being cleared
    a_store_not_cleared: assert property (@(posedge clock) disable iff (reset)
        !(store_pixel && count.clear_frame));

    a_report_start_pulse: assert property (@(posedge clock) disable iff (reset)
        report_start |=> !report_start);

endmodule

//--- logic/position_counters.sv
// position_counters
// pixel and line position inside the current quadrant, plus the
// quadrant column and row, combined into the quadrant index
`timescale 1ns/1ps

module position_counters
    import quadrant_stats_pkg::*;
#(
    parameter int IMAGE_WIDTH  = 8,
    parameter int IMAGE_HEIGHT = 4,
    parameter int QUAD_WIDTH   = 4,
    parameter int QUAD_HEIGHT  = 2
) (
    input  logic             clock,
    input  logic             reset,
    capture_count_if.counters count
);

    localparam int NUM_COLS    = IMAGE_WIDTH / QUAD_WIDTH;
    localparam int NUM_ROWS    = IMAGE_HEIGHT / QUAD_HEIGHT;
    localparam int NUM_QUADS   = NUM_COLS * NUM_ROWS;
    localparam int INDEX_WIDTH = quad_index_width(NUM_QUADS);
    localparam int PIX_W       = quad_index_width(QUAD_WIDTH);
    localparam int COL_W       = quad_index_width(NUM_COLS);
    localparam int LINE_W      = quad_index_width(QUAD_HEIGHT);
    localparam int ROW_W       = quad_index_width(NUM_ROWS);

    localparam logic [PIX_W-1:0]  LAST_PIXEL = PIX_W'(QUAD_WIDTH - 1);
    localparam logic [COL_W-1:0]  LAST_COL   = COL_W'(NUM_COLS - 1);
    localparam logic [LINE_W-1:0] LAST_LINE  = LINE_W'(QUAD_HEIGHT - 1);
    localparam logic [ROW_W-1:0]  LAST_ROW   = ROW_W'(NUM_ROWS - 1);

    logic [PIX_W-1:0]  pixel_count;  // pixel inside quadrant column
    logic [COL_W-1:0]  quad_col;
    logic [LINE_W-1:0] line_count;   // line inside quadrant row
    logic [ROW_W-1:0]  quad_row;

    // horizontal position
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pixel_count <= '0;
            quad_col    <= '0;
        end else if (count.clear_frame || count.clear_line) begin
            pixel_count <= '0;
            quad_col    <= '0;
        end else if (count.step_pixel) begin
            if (count.last_pixel_in_quad) begin
                pixel_count <= '0;
                quad_col    <= (quad_col == LAST_COL) ? '0 : quad_col + 1'b1;
            end else begin
                pixel_count <= pixel_count + 1'b1;
            end
        end
    end

    // vertical position
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_count <= '0;
            quad_row   <= '0;
        end else if (count.clear_frame) begin
            line_count <= '0;
            quad_row   <= '0;
        end else if (count.step_line) begin
            if (count.last_line_in_quad) begin
                line_count <= '0;
                quad_row   <= (quad_row == LAST_ROW) ? '0 : quad_row + 1'b1;
            end else begin
                line_count <= line_count + 1'b1;
            end
        end
    end

    assign count.last_pixel_in_quad = (pixel_count == LAST_PIXEL);
    assign count.last_line_in_quad  = (line_count == LAST_LINE);
    assign count.quad_index = INDEX_WIDTH'(quad_row * NUM_COLS + quad_col);

    // once the last row is left, no pixel comes before the next frame clear
    a_row_in_range: assert property (@(posedge clock) disable iff (reset)
        (count.step_line && count.last_line_in_quad && quad_row == LAST_ROW)
        |=> (!count.step_pixel until count.clear_frame));

endmodule

//--- logic/quadrant_accumulator.sv
// quadrant_accumulator
// builds the green field of each pixel and adds it into the sum of the
// quadrant it falls in; sums saturate and are read back by index
`timescale 1ns/1ps

module quadrant_accumulator
    import camera_pkg::*;
    import quadrant_stats_pkg::*;
#(
    parameter  int IMAGE_WIDTH  = 8,
    parameter  int IMAGE_HEIGHT = 4,
    parameter  int QUAD_WIDTH   = 4,
    parameter  int QUAD_HEIGHT  = 2,
    localparam int NUM_QUADS    = (IMAGE_WIDTH / QUAD_WIDTH) * (IMAGE_HEIGHT / QUAD_HEIGHT),
    localparam int INDEX_WIDTH  = quad_index_width(NUM_QUADS)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  pixel_byte_t            pixel_byte,
    input  logic                   capture_first,
    input  logic                   store_pixel,
    capture_count_if.reader        count,
    input  logic [INDEX_WIDTH-1:0] read_index,
    output quad_sum_t              read_sum
);

    pixel_byte_t          first_byte;   // red and upper green
    green_t               green;
    logic [SUM_WIDTH:0]   wide_sum;     // one extra bit for overflow
    quad_sum_t            next_sum;
    quad_sum_t            sums [NUM_QUADS];

    always_ff @(posedge clock) begin
        if (capture_first) begin
            first_byte <= pixel_byte;
        end
    end

    // second byte is still on the bus while store_pixel is high
    assign green    = extract_green(first_byte, pixel_byte);
    assign wide_sum = {1'b0, sums[count.quad_index]} + (SUM_WIDTH + 1)'(green);
    assign next_sum = wide_sum[SUM_WIDTH] ? SUM_MAX : wide_sum[SUM_WIDTH-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_QUADS; i++) begin
                sums[i] <= '0;
            end
        end else if (count.clear_frame) begin
            for (int i = 0; i < NUM_QUADS; i++) begin
                sums[i] <= '0;
            end
        end else if (store_pixel) begin
            sums[count.quad_index] <= next_sum;
        end
    end

    assign read_sum = sums[read_index];  // combinational read for the sender

endmodule

//--- logic/result_sender.sv
// result_sender
// sends every quadrant sum in index order over four-phase req/ack
`timescale 1ns/1ps

module result_sender
    import quadrant_stats_pkg::*;
#(
    parameter  int NUM_QUADS   = 4,
    localparam int INDEX_WIDTH = quad_index_width(NUM_QUADS)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   report_start,
    output logic                   report_done,
    output logic [INDEX_WIDTH-1:0] read_index,
    input  quad_sum_t              read_sum,
    output logic                   result_req,
    input  logic                   result_ack,
    output logic [INDEX_WIDTH-1:0] result_quadrant,
    output quad_sum_t              result_sum
);

    typedef enum logic [1:0] {
        s_idle,
        s_load,     // latch the next sum
        s_req,      // req high, waiting for ack
        s_release   // req low, waiting for ack to drop
    } sender_state_t;

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(NUM_QUADS - 1);

    sender_state_t          state;
    logic [INDEX_WIDTH-1:0] index;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s_idle;
            index <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (report_start) begin
                        index <= '0;
                        state <= s_load;
                    end
                end
                s_load:    state <= s_req;
                s_req:     if (result_ack) state <= s_release;
                s_release: begin
                    if (!result_ack) begin
                        if (index == LAST_INDEX) begin
                            state <= s_idle;
                        end else begin
                            index <= index + 1'b1;
                            state <= s_load;
                        end
                    end
                end
                default:   state <= s_idle;
            endcase
        end
    end

    // data is held from load until the next load
    always_ff @(posedge clock) begin
        if (state == s_load) begin
            result_quadrant <= index;
            result_sum      <= read_sum;
        end
    end

    assign read_index  = index;
    assign result_req  = (state == s_req);
    assign report_done = (state == s_release) && !result_ack && (index == LAST_INDEX);

    // req is held until the receiver answers
    a_req_held: assert property (@(posedge clock) disable iff (reset)
        (result_req && !result_ack) |=> result_req);

endmodule

//--- logic/ov7670_quadrant_capture.sv
// ov7670_quadrant_capture
// top level: captures one OV7670 RGB565 frame per start and reports the
// green sum of each quadrant over a req/ack handshake
`timescale 1ns/1ps

module ov7670_quadrant_capture
    import camera_pkg::*;
    import quadrant_stats_pkg::*;
#(
    parameter  int IMAGE_WIDTH  = 8,
    parameter  int IMAGE_HEIGHT = 4,
    parameter  int QUAD_WIDTH   = 4,
    parameter  int QUAD_HEIGHT  = 2,
    localparam int NUM_QUADS    = (IMAGE_WIDTH / QUAD_WIDTH) * (IMAGE_HEIGHT / QUAD_HEIGHT),
    localparam int INDEX_WIDTH  = quad_index_width(NUM_QUADS)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   vsync,
    input  logic                   href,
    input  logic                   byte_valid,
    input  pixel_byte_t            pixel_byte,
    output logic                   result_req,
    input  logic                   result_ack,
    output logic [INDEX_WIDTH-1:0] result_quadrant,
    output quad_sum_t              result_sum,
    output logic                   busy
);

    logic                   store_pixel;
    logic                   capture_first;
    logic                   report_start;
    logic                   report_done;
    logic [INDEX_WIDTH-1:0] read_index;
    quad_sum_t              read_sum;

    capture_count_if #(.NUM_QUADS(NUM_QUADS)) count_if ();

    capture_control control_i (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .vsync         (vsync),
        .href          (href),
        .byte_valid    (byte_valid),
        .count         (count_if.control),
        .store_pixel   (store_pixel),
        .capture_first (capture_first),
        .report_start  (report_start),
        .report_done   (report_done),
        .busy          (busy)
    );

    position_counters #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .QUAD_WIDTH   (QUAD_WIDTH),
        .QUAD_HEIGHT  (QUAD_HEIGHT)
    ) counters_i (
        .clock (clock),
        .reset (reset),
        .count (count_if.counters)
    );

    quadrant_accumulator #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .QUAD_WIDTH   (QUAD_WIDTH),
        .QUAD_HEIGHT  (QUAD_HEIGHT)
    ) accumulator_i (
        .clock         (clock),
        .reset         (reset),
        .pixel_byte    (pixel_byte),
        .capture_first (capture_first),
        .store_pixel   (store_pixel),
        .count         (count_if.reader),
        .read_index    (read_index),
        .read_sum      (read_sum)
    );

    result_sender #(.NUM_QUADS(NUM_QUADS)) sender_i (
        .clock           (clock),
        .reset           (reset),
        .report_start    (report_start),
        .report_done     (report_done),
        .read_index      (read_index),
        .read_sum        (read_sum),
        .result_req      (result_req),
        .result_ack      (result_ack),
        .result_quadrant (result_quadrant),
        .result_sum      (result_sum)
    );

endmodule

//--- verification/ov7670_quadrant_capture_tb.sv
// ov7670_quadrant_capture_tb
// plays table-driven OV7670 frames into the capture block, builds the
// green sum of each quadrant and checks the req/ack results against it
`timescale 1ns/1ps

module ov7670_quadrant_capture_tb
    import camera_pkg::*;
    import quadrant_stats_pkg::*;
();

    localparam int CLOCK_PERIOD    = 40;
    localparam int DRIVE_DELAY     = 5;
    localparam int IMAGE_WIDTH     = 8;
    localparam int IMAGE_HEIGHT    = 4;
    localparam int QUAD_WIDTH      = 4;
    localparam int QUAD_HEIGHT     = 2;
    localparam int NUM_COLS        = IMAGE_WIDTH / QUAD_WIDTH;
    localparam int NUM_QUADS       = NUM_COLS * (IMAGE_HEIGHT / QUAD_HEIGHT);
    localparam int INDEX_WIDTH     = (NUM_QUADS > 1) ? $clog2(NUM_QUADS) : 1;
    localparam int BYTE_SPACING    = 5;
    localparam int HREF_GAP        = 6;
    localparam int MAX_ACK_DELAY   = 7;
    localparam int NUM_ROWS        = 6;
    localparam int LINE_CYCLES     = 3 + IMAGE_WIDTH * 2 * BYTE_SPACING + HREF_GAP;
    localparam int FRAME_CYCLES    = 8 + IMAGE_HEIGHT * LINE_CYCLES + 24;
    localparam int REPORT_CYCLES   = NUM_QUADS * (MAX_ACK_DELAY + 8) + 10;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_ROWS * (FRAME_CYCLES + REPORT_CYCLES) + 4);

    typedef struct packed {
        logic       start_given;
        logic       random_bytes;  // else fixed pattern
        logic [3:0] ack_delay;     // cycles from req to ack
        logic       stray_bytes;   // strobes while href is low
    } frame_row_t;

    logic                   clock;
    logic                   reset;
    logic                   start;
    logic                   vsync;
    logic                   href;
    logic                   byte_valid;
    pixel_byte_t            pixel_byte;
    logic                   result_req;
    logic                   result_ack;
    logic [INDEX_WIDTH-1:0] result_quadrant;
    quad_sum_t              result_sum;
    logic                   busy;

    frame_row_t  test_table [NUM_ROWS];
    quad_sum_t   expected_sums [NUM_QUADS];
    logic [15:0] lfsr_state;
    int          ack_delay;
    int          result_count;  // results seen in the current frame
    int          error_count;
    int          check_count;
    logic        busy_seen;

    ov7670_quadrant_capture #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .QUAD_WIDTH   (QUAD_WIDTH),
        .QUAD_HEIGHT  (QUAD_HEIGHT)
    ) dut_i (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .vsync           (vsync),
        .href            (href),
        .byte_valid      (byte_valid),
        .pixel_byte      (pixel_byte),
        .result_req      (result_req),
        .result_ack      (result_ack),
        .result_quadrant (result_quadrant),
        .result_sum      (result_sum),
        .busy            (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 16'hb400;
        end
        return shifted;
    endfunction

    task automatic draw_random_byte(output pixel_byte_t value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value      = {value[6:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic pixel_byte_t pattern_byte(input int line, input int pixel, input int half);
        return pixel_byte_t'((line * 16 + pixel * 2 + half) * 37 + 29);
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_condition(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("%s", what);
        end
    endtask

    // green is the low 3 bits of byte one above the high 3 bits of byte two
    task automatic add_expected(input int line, input int pixel,
                                input pixel_byte_t first, input pixel_byte_t second);
        int         quad;
        int         total;
        logic [5:0] green;
        green = {first[2:0], second[7:5]};
        quad  = (line / QUAD_HEIGHT) * NUM_COLS + pixel / QUAD_WIDTH;
        total = int'(expected_sums[quad]) + int'(green);
        expected_sums[quad] = (total >= (1 << SUM_WIDTH)) ? '1 : quad_sum_t'(total);
    endtask

    task automatic send_byte(input pixel_byte_t value);
        pixel_byte = value;
        byte_valid = 1'b1;
        next_cycle();
        byte_valid = 1'b0;
        repeat (BYTE_SPACING - 1) next_cycle();
    endtask

    task automatic play_frame(input frame_row_t row);
        pixel_byte_t first;
        pixel_byte_t second;
        start = row.start_given;
        next_cycle();
        start = 1'b0;
        repeat (3) next_cycle();
        vsync = 1'b0;  // frame begins here
        repeat (3) next_cycle();
        for (int line = 0; line < IMAGE_HEIGHT; line++) begin
            href = 1'b1;
            repeat (2) next_cycle();
            for (int pixel = 0; pixel < IMAGE_WIDTH; pixel++) begin
                if (row.random_bytes) begin
                    draw_random_byte(first);
                    draw_random_byte(second);
                end else begin
                    first  = pattern_byte(line, pixel, 0);
                    second = pattern_byte(line, pixel, 1);
                end
                send_byte(first);
                send_byte(second);
                add_expected(line, pixel, first, second);
            end
            next_cycle();
            href = 1'b0;
            for (int gap = 0; gap < HREF_GAP; gap++) begin
                if (row.stray_bytes && gap == 2) begin
                    pixel_byte = 8'hff;  // would add the most green if taken
                    byte_valid = 1'b1;
                end
                next_cycle();
                byte_valid = 1'b0;
            end
        end
        vsync = 1'b1;  // frame end
        next_cycle();
    endtask

    task automatic run_row(input int index, input frame_row_t row);
        int waited;
        for (int q = 0; q < NUM_QUADS; q++) begin
            expected_sums[q] = '0;
        end
        result_count = 0;
        busy_seen    = 1'b0;
        ack_delay    = row.ack_delay;
        waited       = 0;
        play_frame(row);
        if (row.start_given) begin
            while (busy && waited < REPORT_CYCLES) begin
                next_cycle();
                waited++;
            end
            check_condition(!busy, $sformatf("frame %0d: report did not finish in time", index));
            repeat (4) next_cycle();
            check_condition(result_count == NUM_QUADS,
                            $sformatf("frame %0d reported %0d results instead of %0d",
                                      index, result_count, NUM_QUADS));
        end else begin
            repeat (20) next_cycle();
            check_condition(!busy_seen, $sformatf("frame %0d: busy rose without start", index));
            check_condition(result_count == 0,
                            $sformatf("frame %0d: results were sent without start", index));
        end
    endtask

    task automatic load_table();
        test_table[0] = '{1'b1, 1'b1, 4'd0, 1'b0};
        test_table[1] = '{1'b1, 1'b1, 4'd2, 1'b0};  // second frame, sums start over
        test_table[2] = '{1'b0, 1'b1, 4'd0, 1'b0};  // no start, block stays idle
        test_table[3] = '{1'b1, 1'b0, 4'd7, 1'b0};  // slow ack
        test_table[4] = '{1'b1, 1'b1, 4'd1, 1'b1};
        test_table[5] = '{1'b1, 1'b0, 4'd7, 1'b1};
    endtask

    // answers each req after the row's delay and checks its result
    initial begin
        result_ack = 1'b0;
        forever begin
            next_cycle();
            if (result_req) begin
                check_condition(result_count < NUM_QUADS,
                                "more results than quadrants in a frame");
                compare_value("result_quadrant", 32'(result_quadrant), 32'(result_count));
                if (result_count < NUM_QUADS) begin
                    compare_value("result_sum", 32'(result_sum), 32'(expected_sums[result_count]));
                end
                result_count++;
                repeat (ack_delay) next_cycle();
                result_ack = 1'b1;
                do begin
                    next_cycle();
                end while (result_req);
                result_ack = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            next_cycle();
            if (busy) begin
                busy_seen = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog ran out after %0d cycles before all frames were done",
                 WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("test failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        vsync        = 1'b1;  // between frames
        href         = 1'b0;
        byte_valid   = 1'b0;
        pixel_byte   = '0;
        lfsr_state   = 16'd88;
        error_count  = 0;
        check_count  = 0;
        result_count = 0;
        ack_delay    = 0;
        busy_seen    = 1'b0;
        load_table();
        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        next_cycle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r, test_table[r]);
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- ov7670_quadrant_capture.f
logic/camera_pkg.sv
logic/quadrant_stats_pkg.sv
logic/capture_count_if.sv
logic/capture_control.sv
logic/position_counters.sv
logic/quadrant_accumulator.sv
logic/result_sender.sv
logic/ov7670_quadrant_capture.sv
verification/ov7670_quadrant_capture_tb.sv

//--- Bender.yml
package:
  name: ov7670_quadrant_capture

sources:
  - logic/camera_pkg.sv
  - logic/quadrant_stats_pkg.sv
  - logic/capture_count_if.sv
  - logic/capture_control.sv
  - logic/position_counters.sv
  - logic/quadrant_accumulator.sv
  - logic/result_sender.sv
  - logic/ov7670_quadrant_capture.sv
  - target: test
    files:
      - verification/ov7670_quadrant_capture_tb.sv
